// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Stall bits from 0 up: pc, fetch, decode, execute, memory, write-back
  localparam int STAGE_NUM = 6;

  // RV32 major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Load/store width or branch condition
  typedef logic [2:0] func3_t;

  typedef logic [STAGE_NUM-1:0] stall_t;

endpackage

// ==== decode/decode.sv ====
`timescale 1ns/100ps

module decode (
  input  logic                       clk,
  input  logic                       rstn,
  input  cpu_pkg::stall_t            stall_i,
  input  logic [cpu_pkg::XLEN-1:0]   pc_i,
  input  logic [cpu_pkg::XLEN-1:0]   inst_i,
  input  logic [cpu_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [cpu_pkg::XLEN-1:0]   rs2_data_i,
  input  logic                       ex_wreg_i,
  input  logic [cpu_pkg::REG_AW-1:0] ex_rd_i,
  input  logic                       ex_memrd_i,
  input  logic [cpu_pkg::XLEN-1:0]   ex_result_i,
  input  logic                       mem_wreg_i,
  input  logic [cpu_pkg::REG_AW-1:0] mem_rd_i,
  input  logic                       mem_memrd_i,
  input  logic [cpu_pkg::XLEN-1:0]   mem_result_i,
  output logic [cpu_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [cpu_pkg::REG_AW-1:0] rs2_addr_o,
  output logic                       stall_req_o,
  output logic                       flush_o,
  output logic [cpu_pkg::XLEN-1:0]   branch_target_o,
  output logic [cpu_pkg::XLEN-1:0]   ex_pc_o,
  output cpu_pkg::alu_op_e           ex_aluop_o,
  output logic                       ex_alusrc_o,
  output logic [cpu_pkg::XLEN-1:0]   ex_imm_o,
  output logic [cpu_pkg::XLEN-1:0]   ex_rs1_o,
  output logic [cpu_pkg::XLEN-1:0]   ex_rs2_o,
  output logic [cpu_pkg::REG_AW-1:0] ex_rd_o,
  output logic                       ex_wreg_o,
  output logic                       ex_memrd_o,
  output logic                       ex_memwr_o,
  output cpu_pkg::func3_t            ex_func3_o,
  output logic                       ex_is_jal_o
);

  cpu_pkg::opcode_e           opcode;
  cpu_pkg::func3_t            func3;
  cpu_pkg::alu_op_e           aluop;
  logic [cpu_pkg::REG_AW-1:0] rd;
  logic [cpu_pkg::XLEN-1:0]   imm;
  logic [cpu_pkg::XLEN-1:0]   rs1_val;
  logic [cpu_pkg::XLEN-1:0]   rs2_val;
  logic                       alusrc;
  logic                       wreg;
  logic                       memrd;
  logic                       memwr;
  logic                       is_jal;
  logic                       use_rs1;
  logic                       use_rs2;
  logic                       taken;

  assign opcode     = cpu_pkg::opcode_e'(inst_i[6:0]);
  assign func3      = inst_i[14:12];
  assign rd         = inst_i[11:7];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  // Youngest producer wins, rd is never x0 when a write is enabled
  function automatic logic [cpu_pkg::XLEN-1:0] fwd(
    input logic [cpu_pkg::REG_AW-1:0] addr,
    input logic [cpu_pkg::XLEN-1:0]   rf_data
  );
    if (ex_wreg_i && ex_rd_i == addr) begin
      return ex_result_i;
    end
    if (mem_wreg_i && mem_rd_i == addr) begin
      return mem_result_i;
    end
    return rf_data;
  endfunction

  function automatic logic load_pending(input logic [cpu_pkg::REG_AW-1:0] addr);
    return (ex_memrd_i && ex_wreg_i && ex_rd_i == addr) ||
           (mem_memrd_i && mem_wreg_i && mem_rd_i == addr);
  endfunction

  always_comb begin
    aluop   = cpu_pkg::ALU_ADD;
    alusrc  = 1'b1;
    imm     = {{20{inst_i[31]}}, inst_i[31:20]};
    wreg    = 1'b0;
    memrd   = 1'b0;
    memwr   = 1'b0;
    is_jal  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      cpu_pkg::OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        alusrc  = 1'b0;
        wreg    = 1'b1;
        case (func3)
          3'b000:  aluop = inst_i[30] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
          3'b010:  aluop = cpu_pkg::ALU_SLT;
          3'b100:  aluop = cpu_pkg::ALU_XOR;
          3'b110:  aluop = cpu_pkg::ALU_OR;
          3'b111:  aluop = cpu_pkg::ALU_AND;
          default: wreg = 1'b0;
        endcase
      end
      cpu_pkg::OP_IMM: begin
        // ADDI only
        use_rs1 = 1'b1;
        wreg    = (func3 == 3'b000);
      end
      cpu_pkg::LUI: begin
        aluop = cpu_pkg::ALU_PASS_B;
        imm   = {inst_i[31:12], 12'b0};
        wreg  = 1'b1;
      end
      cpu_pkg::LOAD: begin
        use_rs1 = 1'b1;
        wreg    = 1'b1;
        memrd   = 1'b1;
      end
      cpu_pkg::STORE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        memwr   = 1'b1;
        imm     = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      end
      cpu_pkg::BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                   inst_i[11:8], 1'b0};
      end
      cpu_pkg::JAL: begin
        wreg   = 1'b1;
        is_jal = 1'b1;
        imm    = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
      end
      default: begin
      end
    endcase
    if (rd == '0) begin
      wreg = 1'b0;
    end
  end

  always_comb begin
    rs1_val     = fwd(rs1_addr_o, rs1_data_i);
    rs2_val     = fwd(rs2_addr_o, rs2_data_i);
    stall_req_o = (use_rs1 && load_pending(rs1_addr_o)) ||
                  (use_rs2 && load_pending(rs2_addr_o));
  end

  // BEQ is func3 000, BNE is 001
  assign taken = (opcode == cpu_pkg::JAL) ||
                 (opcode == cpu_pkg::BRANCH && func3[2:1] == 2'b00 &&
                  ((rs1_val == rs2_val) != func3[0]));
  // Operands are not valid yet while waiting on a load
  assign flush_o         = taken && !stall_req_o;
  assign branch_target_o = pc_i + imm;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_wreg_o   <= 1'b0;
      ex_memrd_o  <= 1'b0;
      ex_memwr_o  <= 1'b0;
      ex_is_jal_o <= 1'b0;
    end else if (!stall_i[3]) begin
      ex_wreg_o   <= wreg && !stall_i[2];
      ex_memrd_o  <= memrd && !stall_i[2];
      ex_memwr_o  <= memwr && !stall_i[2];
      ex_is_jal_o <= is_jal && !stall_i[2];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[3]) begin
      ex_pc_o     <= pc_i;
      ex_aluop_o  <= aluop;
      ex_alusrc_o <= alusrc;
      ex_imm_o    <= imm;
      ex_rs1_o    <= rs1_val;
      ex_rs2_o    <= rs2_val;
      ex_rd_o     <= rd;
      ex_func3_o  <= func3;
    end
  end

endmodule

// ==== rtl/cpu.sv ====
`timescale 1ns/100ps

module cpu #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [cpu_pkg::XLEN-1:0] inst_out_i,
  output logic                     inst_read_o,
  output logic [cpu_pkg::XLEN-1:0] inst_addr_o,
  input  logic [cpu_pkg::XLEN-1:0] data_rdata_i,
  output logic                     data_read_o,
  output logic                     data_write_o,
  output logic [3:0]               data_web_o,
  output logic [cpu_pkg::XLEN-1:0] data_addr_o,
  output logic [cpu_pkg::XLEN-1:0] data_wdata_o,
  // Held levels from the fetch and data sides
  input  logic                     stall_if_i,
  input  logic                     stall_mem_i
);

  cpu_pkg::stall_t            stall;
  logic                       stall_id;
  logic                       flush;
  logic [cpu_pkg::XLEN-1:0]   branch_target;

  logic [cpu_pkg::XLEN-1:0]   id_pc;
  logic [cpu_pkg::XLEN-1:0]   id_inst;
  logic [cpu_pkg::REG_AW-1:0] rs1_addr;
  logic [cpu_pkg::REG_AW-1:0] rs2_addr;
  logic [cpu_pkg::XLEN-1:0]   rs1_data;
  logic [cpu_pkg::XLEN-1:0]   rs2_data;

  logic [cpu_pkg::XLEN-1:0]   ex_pc;
  cpu_pkg::alu_op_e           ex_aluop;
  logic                       ex_alusrc;
  logic [cpu_pkg::XLEN-1:0]   ex_imm;
  logic [cpu_pkg::XLEN-1:0]   ex_rs1;
  logic [cpu_pkg::XLEN-1:0]   ex_rs2;
  logic [cpu_pkg::REG_AW-1:0] ex_rd;
  logic                       ex_wreg;
  logic                       ex_memrd;
  logic                       ex_memwr;
  cpu_pkg::func3_t            ex_func3;
  logic                       ex_is_jal;
  logic [cpu_pkg::XLEN-1:0]   ex_result;

  logic [cpu_pkg::REG_AW-1:0] mem_rd;
  logic                       mem_wreg;
  logic                       mem_memrd;
  logic                       mem_memwr;
  cpu_pkg::func3_t            mem_func3;
  logic [cpu_pkg::XLEN-1:0]   mem_result;
  logic [cpu_pkg::XLEN-1:0]   mem_store_data;

  logic                       wb_we;
  logic [cpu_pkg::REG_AW-1:0] wb_rd;
  logic [cpu_pkg::XLEN-1:0]   wb_wdata;

  regfile i_regfile (
    .clk      (clk),
    .rstn     (rstn),
    .we_i     (wb_we),
    .waddr_i  (wb_rd),
    .wdata_i  (wb_wdata),
    .raddr1_i (rs1_addr),
    .raddr2_i (rs2_addr),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  stall_ctrl i_stall_ctrl (
    .stall_if_i  (stall_if_i),
    .stall_id_i  (stall_id),
    .stall_mem_i (stall_mem_i),
    .stall_o     (stall)
  );

  ifetch #(
    .RESET_PC (RESET_PC)
  ) i_ifetch (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .flush_i         (flush),
    .branch_target_i (branch_target),
    .inst_i          (inst_out_i),
    .inst_read_o     (inst_read_o),
    .inst_addr_o     (inst_addr_o),
    .id_pc_o         (id_pc),
    .id_inst_o       (id_inst)
  );

  decode i_decode (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .pc_i            (id_pc),
    .inst_i          (id_inst),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .ex_wreg_i       (ex_wreg),
    .ex_rd_i         (ex_rd),
    .ex_memrd_i      (ex_memrd),
    .ex_result_i     (ex_result),
    .mem_wreg_i      (mem_wreg),
    .mem_rd_i        (mem_rd),
    .mem_memrd_i     (mem_memrd),
    .mem_result_i    (mem_result),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .stall_req_o     (stall_id),
    .flush_o         (flush),
    .branch_target_o (branch_target),
    .ex_pc_o         (ex_pc),
    .ex_aluop_o      (ex_aluop),
    .ex_alusrc_o     (ex_alusrc),
    .ex_imm_o        (ex_imm),
    .ex_rs1_o        (ex_rs1),
    .ex_rs2_o        (ex_rs2),
    .ex_rd_o         (ex_rd),
    .ex_wreg_o       (ex_wreg),
    .ex_memrd_o      (ex_memrd),
    .ex_memwr_o      (ex_memwr),
    .ex_func3_o      (ex_func3),
    .ex_is_jal_o     (ex_is_jal)
  );

  execute i_execute (
    .clk              (clk),
    .rstn             (rstn),
    .stall_i          (stall),
    .ex_pc_i          (ex_pc),
    .ex_aluop_i       (ex_aluop),
    .ex_alusrc_i      (ex_alusrc),
    .ex_imm_i         (ex_imm),
    .ex_rs1_i         (ex_rs1),
    .ex_rs2_i         (ex_rs2),
    .ex_rd_i          (ex_rd),
    .ex_wreg_i        (ex_wreg),
    .ex_memrd_i       (ex_memrd),
    .ex_memwr_i       (ex_memwr),
    .ex_func3_i       (ex_func3),
    .ex_is_jal_i      (ex_is_jal),
    .ex_result_o      (ex_result),
    .mem_rd_o         (mem_rd),
    .mem_wreg_o       (mem_wreg),
    .mem_memrd_o      (mem_memrd),
    .mem_memwr_o      (mem_memwr),
    .mem_func3_o      (mem_func3),
    .mem_result_o     (mem_result),
    .mem_store_data_o (mem_store_data)
  );

  lsu i_lsu (
    .clk              (clk),
    .rstn             (rstn),
    .stall_i          (stall),
    .mem_rd_i         (mem_rd),
    .mem_wreg_i       (mem_wreg),
    .mem_memrd_i      (mem_memrd),
    .mem_memwr_i      (mem_memwr),
    .mem_func3_i      (mem_func3),
    .mem_result_i     (mem_result),
    .mem_store_data_i (mem_store_data),
    .data_rdata_i     (data_rdata_i),
    .data_read_o      (data_read_o),
    .data_write_o     (data_write_o),
    .data_web_o       (data_web_o),
    .data_addr_o      (data_addr_o),
    .data_wdata_o     (data_wdata_o),
    .wb_we_o          (wb_we),
    .wb_rd_o          (wb_rd),
    .wb_wdata_o       (wb_wdata)
  );

endmodule

// ==== rtl/execute.sv ====
`timescale 1ns/100ps

module execute (
  input  logic                       clk,
  input  logic                       rstn,
  input  cpu_pkg::stall_t            stall_i,
  input  logic [cpu_pkg::XLEN-1:0]   ex_pc_i,
  input  cpu_pkg::alu_op_e           ex_aluop_i,
  input  logic                       ex_alusrc_i,
  input  logic [cpu_pkg::XLEN-1:0]   ex_imm_i,
  input  logic [cpu_pkg::XLEN-1:0]   ex_rs1_i,
  input  logic [cpu_pkg::XLEN-1:0]   ex_rs2_i,
  input  logic [cpu_pkg::REG_AW-1:0] ex_rd_i,
  input  logic                       ex_wreg_i,
  input  logic                       ex_memrd_i,
  input  logic                       ex_memwr_i,
  input  cpu_pkg::func3_t            ex_func3_i,
  input  logic                       ex_is_jal_i,
  output logic [cpu_pkg::XLEN-1:0]   ex_result_o,
  output logic [cpu_pkg::REG_AW-1:0] mem_rd_o,
  output logic                       mem_wreg_o,
  output logic                       mem_memrd_o,
  output logic                       mem_memwr_o,
  output cpu_pkg::func3_t            mem_func3_o,
  output logic [cpu_pkg::XLEN-1:0]   mem_result_o,
  output logic [cpu_pkg::XLEN-1:0]   mem_store_data_o
);

  logic [cpu_pkg::XLEN-1:0] op_b;

  assign op_b = ex_alusrc_i ? ex_imm_i : ex_rs2_i;

  // Loads and stores compute their address with ALU_ADD
  always_comb begin
    if (ex_is_jal_i) begin
      ex_result_o = ex_pc_i + 32'd4;
    end else begin
      case (ex_aluop_i)
        cpu_pkg::ALU_SUB:    ex_result_o = ex_rs1_i - op_b;
        cpu_pkg::ALU_AND:    ex_result_o = ex_rs1_i & op_b;
        cpu_pkg::ALU_OR:     ex_result_o = ex_rs1_i | op_b;
        cpu_pkg::ALU_XOR:    ex_result_o = ex_rs1_i ^ op_b;
        cpu_pkg::ALU_SLT:    ex_result_o = {{(cpu_pkg::XLEN-1){1'b0}},
                                            $signed(ex_rs1_i) < $signed(op_b)};
        cpu_pkg::ALU_PASS_B: ex_result_o = op_b;
        default:             ex_result_o = ex_rs1_i + op_b;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_wreg_o  <= 1'b0;
      mem_memrd_o <= 1'b0;
      mem_memwr_o <= 1'b0;
    end else if (!stall_i[4]) begin
      mem_wreg_o  <= ex_wreg_i && !stall_i[3];
      mem_memrd_o <= ex_memrd_i && !stall_i[3];
      mem_memwr_o <= ex_memwr_i && !stall_i[3];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[4]) begin
      mem_rd_o         <= ex_rd_i;
      mem_func3_o      <= ex_func3_i;
      mem_result_o     <= ex_result_o;
      mem_store_data_o <= ex_rs2_i;
    end
  end

endmodule

// ==== rtl/ifetch.sv ====
`timescale 1ns/100ps

module ifetch #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  cpu_pkg::stall_t          stall_i,
  input  logic                     flush_i,
  input  logic [cpu_pkg::XLEN-1:0] branch_target_i,
  input  logic [cpu_pkg::XLEN-1:0] inst_i,
  output logic                     inst_read_o,
  output logic [cpu_pkg::XLEN-1:0] inst_addr_o,
  output logic [cpu_pkg::XLEN-1:0] id_pc_o,
  output logic [cpu_pkg::XLEN-1:0] id_inst_o
);

  // addi x0, x0, 0
  localparam logic [cpu_pkg::XLEN-1:0] NOP = 32'h0000_0013;

  logic [cpu_pkg::XLEN-1:0] pc;
  logic                     redirect;

  // Redirect once the branch leaves decode, even while fetch is held
  assign redirect = flush_i && !stall_i[2];

  // Memory answers in the same cycle, a held pc just repeats the read
  assign inst_read_o = 1'b1;
  assign inst_addr_o = pc;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= branch_target_i;
    end else if (!stall_i[0]) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_inst_o <= NOP;
    end else if (!stall_i[2]) begin
      id_inst_o <= (flush_i || stall_i[1]) ? NOP : inst_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[2]) begin
      id_pc_o <= pc;
    end
  end

endmodule

// ==== rtl/lsu.sv ====
`timescale 1ns/100ps

module lsu (
  input  logic                       clk,
  input  logic                       rstn,
  input  cpu_pkg::stall_t            stall_i,
  input  logic [cpu_pkg::REG_AW-1:0] mem_rd_i,
  input  logic                       mem_wreg_i,
  input  logic                       mem_memrd_i,
  input  logic                       mem_memwr_i,
  input  cpu_pkg::func3_t            mem_func3_i,
  input  logic [cpu_pkg::XLEN-1:0]   mem_result_i,
  input  logic [cpu_pkg::XLEN-1:0]   mem_store_data_i,
  input  logic [cpu_pkg::XLEN-1:0]   data_rdata_i,
  output logic                       data_read_o,
  output logic                       data_write_o,
  output logic [3:0]                 data_web_o,
  output logic [cpu_pkg::XLEN-1:0]   data_addr_o,
  output logic [cpu_pkg::XLEN-1:0]   data_wdata_o,
  output logic                       wb_we_o,
  output logic [cpu_pkg::REG_AW-1:0] wb_rd_o,
  output logic [cpu_pkg::XLEN-1:0]   wb_wdata_o
);

  logic                     mem_byte;
  logic                     wb_memrd;
  logic                     wb_byte;
  logic [1:0]               wb_off;
  logic [cpu_pkg::XLEN-1:0] wb_result;
  logic [cpu_pkg::XLEN-1:0] rdata_shift;

  // SB and LBU have func3[1:0] of zero, SW and LW have 2'b10
  assign mem_byte = (mem_func3_i[1:0] == 2'b00);

  assign data_read_o  = mem_memrd_i;
  assign data_write_o = mem_memwr_i;
  assign data_addr_o  = {mem_result_i[cpu_pkg::XLEN-1:2], 2'b00};

  always_comb begin
    if (!mem_memwr_i) begin
      data_web_o   = 4'b0000;
      data_wdata_o = mem_store_data_i;
    end else if (mem_byte) begin
      data_web_o   = 4'b0001 << mem_result_i[1:0];
      data_wdata_o = {4{mem_store_data_i[7:0]}};
    end else begin
      data_web_o   = 4'b1111;
      data_wdata_o = mem_store_data_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_we_o  <= 1'b0;
      wb_memrd <= 1'b0;
    end else if (!stall_i[5]) begin
      wb_we_o  <= mem_wreg_i && !stall_i[4];
      wb_memrd <= mem_memrd_i && !stall_i[4];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[5]) begin
      wb_rd_o   <= mem_rd_i;
      wb_byte   <= mem_byte;
      wb_off    <= mem_result_i[1:0];
      wb_result <= mem_result_i;
    end
  end

  // Read data arrives now, one cycle after the request
  assign rdata_shift = data_rdata_i >> {wb_off, 3'b000};

  always_comb begin
    if (!wb_memrd) begin
      wb_wdata_o = wb_result;
    end else if (wb_byte) begin
      wb_wdata_o = {24'b0, rdata_shift[7:0]};
    end else begin
      wb_wdata_o = data_rdata_i;
    end
  end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps

module regfile (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       we_i,
  input  logic [cpu_pkg::REG_AW-1:0] waddr_i,
  input  logic [cpu_pkg::XLEN-1:0]   wdata_i,
  input  logic [cpu_pkg::REG_AW-1:0] raddr1_i,
  input  logic [cpu_pkg::REG_AW-1:0] raddr2_i,
  output logic [cpu_pkg::XLEN-1:0]   rdata1_o,
  output logic [cpu_pkg::XLEN-1:0]   rdata2_o
);

  // x0 has no storage
  logic [cpu_pkg::XLEN-1:0] regs [1:31];

  function automatic logic [cpu_pkg::XLEN-1:0] read_reg(
    input logic [cpu_pkg::REG_AW-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    // Write-through from write-back
    if (we_i && addr == waddr_i) begin
      return wdata_i;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata1_o = read_reg(raddr1_i);
    rdata2_o = read_reg(raddr2_i);
  end

endmodule

// ==== rtl/stall_ctrl.sv ====
`timescale 1ns/100ps

module stall_ctrl (
  input  logic            stall_if_i,
  input  logic            stall_id_i,
  input  logic            stall_mem_i,
  output cpu_pkg::stall_t stall_o
);

  // A held stage whose downstream neighbour runs sends it a bubble
  always_comb begin
    if (stall_mem_i) begin
      // Data side busy, freeze everything
      stall_o = 6'b111111;
    end else if (stall_id_i) begin
      // Load-use, bubble into execute
      stall_o = 6'b000111;
    end else if (stall_if_i) begin
      // No instruction this cycle, bubble into decode
      stall_o = 6'b000011;
    end else begin
      stall_o = 6'b000000;
    end
  end

endmodule

// ==== src.f ====
common/cpu_pkg.sv
rtl/regfile.sv
rtl/stall_ctrl.sv
rtl/ifetch.sv
decode/decode.sv
rtl/execute.sv
rtl/lsu.sv
rtl/cpu.sv
testbench/cpu_tb.sv

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;

  localparam int          PROG_LEN = 64;
  localparam logic [31:0] RESET_PC = 32'd0;
  localparam logic [31:0] LAST_PC  = 32'd252;
  localparam int          PHASES   = 4;

  logic        clk;
  logic        rstn;
  logic [31:0] inst_out_i;
  logic [31:0] data_rdata_i;
  logic        stall_if_i;
  logic        stall_mem_i;
  logic        inst_read_o;
  logic [31:0] inst_addr_o;
  logic        data_read_o;
  logic        data_write_o;
  logic [3:0]  data_web_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;

  logic [31:0] prog [PROG_LEN];
  logic [7:0]  dmem [256];
  logic [31:0] rng;
  logic [31:0] rd_pending;
  logic        stall_if_en;
  logic        stall_mem_en;
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_web [$];
  logic [31:0] exp_data [$];
  int          exp_idx;
  int          error_count;
  int          missing_count;
  logic [31:0] got_addr;
  logic [3:0]  got_web;
  logic [31:0] got_data;
  event        store_ev;

  cpu #(.RESET_PC(RESET_PC)) i_cpu (.*);

  // Instruction memory answers in the same cycle
  assign inst_out_i = prog[inst_addr_o[7:2]];

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [4:0] pick_rd();
    return 5'd2 + 5'(xorshift() % 14);
  endfunction

  // x1 holds the data base address 0x80 and is never overwritten
  function automatic void build_program();
    logic [31:0] r;
    logic [31:0] off;
    logic [31:0] k;
    logic [2:0]  f3s [6];
    f3s = '{3'd0, 3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
    prog[0] = enc_i(32'h80, 5'd0, 3'd0, 5'd1, 7'h13);
    for (int i = 1; i < 8; i++) begin
      r = xorshift();
      if (r[0]) prog[i] = {r[31:12], 5'(i + 1), 7'h37};
      else prog[i] = enc_i(r >> 8, 5'd0, 3'd0, 5'(i + 1), 7'h13);
    end
    for (int i = 8; i < PROG_LEN - 1; i++) begin
      r   = xorshift() % 8;
      off = (xorshift() % 256) - 128;
      k   = 2 + xorshift() % 3;
      if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
      case (r)
        0, 1: begin
          r = xorshift() % 6;
          prog[i] = {1'b0, r == 1, 5'b0, 5'(xorshift() % 16), 5'(xorshift() % 16), f3s[r],
                     pick_rd(), 7'h33};
        end
        2: prog[i] = enc_i(off, 5'(xorshift() % 16), 3'd0, pick_rd(), 7'h13);
        3: begin
          if (xorshift() % 2) prog[i] = enc_i(off & ~32'd3, 5'd1, 3'd2, pick_rd(), 7'h03);
          else prog[i] = enc_i(off, 5'd1, 3'd4, pick_rd(), 7'h03);
        end
        4, 5: begin
          if (xorshift() % 2) prog[i] = enc_s(off & ~32'd3, 5'(xorshift() % 16), 5'd1, 3'd2);
          else prog[i] = enc_s(off, 5'(xorshift() % 16), 5'd1, 3'd0);
        end
        6: prog[i] = enc_b(k * 4, 5'(xorshift() % 16), 5'(xorshift() % 16),
                           3'(xorshift() % 2));
        default: prog[i] = enc_j(k * 4, pick_rd());
      endcase
    end
    // Final jump to itself
    prog[PROG_LEN - 1] = enc_j(32'd0, 5'd0);
  endfunction

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a * 37) ^ 8'h5a;
  endfunction

  // Instruction-level model that records every store in program order
  function automatic void run_reference();
    logic [31:0] x [32];
    logic [7:0]  m [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    foreach (x[i]) x[i] = '0;
    foreach (m[i]) m[i] = fill_byte(i);
    pc = 0;
    steps = 0;
    while (pc != LAST_PC && steps < 1000) begin
      ins   = prog[pc[7:2]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      v1    = x[ins[19:15]];
      v2    = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      wr    = 1'b1;
      res   = '0;
      a     = v1 + imm_i;
      steps++;
      case (ins[6:0])
        7'h33: begin
          case (f3)
            3'd0: res = ins[30] ? v1 - v2 : v1 + v2;
            3'd2: res = {31'b0, $signed(v1) < $signed(v2)};
            3'd4: res = v1 ^ v2;
            3'd6: res = v1 | v2;
            default: res = v1 & v2;
          endcase
        end
        7'h13: res = a;
        7'h37: res = {ins[31:12], 12'b0};
        7'h03: begin
          if (f3 == 3'd2) res = {m[a[7:0] + 3], m[a[7:0] + 2], m[a[7:0] + 1], m[a[7:0]]};
          else res = {24'b0, m[a[7:0]]};
        end
        7'h23: begin
          wr = 1'b0;
          a  = v1 + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_addr.push_back({a[31:2], 2'b00});
          if (f3 == 3'd2) begin
            exp_web.push_back(4'hf);
            exp_data.push_back(v2);
            for (int b = 0; b < 4; b++) m[a[7:0] + b] = v2[8*b +: 8];
          end else begin
            exp_web.push_back(4'b0001 << a[1:0]);
            exp_data.push_back({4{v2[7:0]}});
            m[a[7:0]] = v2[7:0];
          end
        end
        7'h63: begin
          wr = 1'b0;
          if ((v1 == v2) != f3[0]) begin
            pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0} - 4;
          end
        end
        default: begin
          res = pc + 4;
          pc  = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0} - 4;
        end
      endcase
      if (wr && rd != 0) x[rd] = res;
      pc = pc + 4;
    end
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Stalls, data memory and store capture on the falling edge
  always @(negedge clk) begin
    data_rdata_i = rd_pending;
    stall_if_i   = stall_if_en && (xorshift() % 4 == 0);
    stall_mem_i  = stall_mem_en && (xorshift() % 4 == 0);
    if (data_read_o && !stall_mem_i) begin
      rd_pending = {dmem[data_addr_o[7:0] + 3], dmem[data_addr_o[7:0] + 2],
                    dmem[data_addr_o[7:0] + 1], dmem[data_addr_o[7:0]]};
    end
    if (data_write_o && !stall_mem_i) begin
      for (int b = 0; b < 4; b++) begin
        if (data_web_o[b]) dmem[data_addr_o[7:0] + b] = data_wdata_o[8*b +: 8];
      end
      got_addr = data_addr_o;
      got_web  = data_web_o;
      got_data = data_wdata_o;
      -> store_ev;
    end
  end

  always @(store_ev) begin
    if (exp_idx >= exp_addr.size()) begin
      error_count++;
      $display("Store to address %h was not expected by the model", got_addr);
    end else begin
      check_value("data_addr_o", exp_addr[exp_idx], got_addr);
      check_value("data_web_o", 32'(exp_web[exp_idx]), 32'(got_web));
      check_value("data_wdata_o", exp_data[exp_idx], got_data);
      exp_idx++;
    end
  end

  initial begin
    #(PHASES * PROG_LEN * 8 * 100 + 50000);
    $display("Run timed out before the program finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    clk = 0;
    rstn = 0;
    data_rdata_i = '0;
    stall_if_i = 0;
    stall_mem_i = 0;
    stall_if_en = 0;
    stall_mem_en = 0;
    rd_pending = '0;
    rng = 32'hf9b2;
    error_count = 0;
    missing_count = 0;
    for (int p = 0; p < PHASES; p++) begin
      @(negedge clk);
      rstn = 0;
      build_program();
      exp_addr.delete();
      exp_web.delete();
      exp_data.delete();
      exp_idx = 0;
      run_reference();
      foreach (dmem[i]) dmem[i] = fill_byte(i);
      repeat (3) begin
        @(negedge clk);
        check_value("data_write_o", 32'd0, 32'(data_write_o));
        check_value("data_read_o", 32'd0, 32'(data_read_o));
        check_value("data_web_o", 32'd0, 32'(data_web_o));
        check_value("inst_read_o", 32'd1, 32'(inst_read_o));
        check_value("inst_addr_o", RESET_PC, inst_addr_o);
      end
      rstn = 1;
      // Later phases add random fetch and data stalls
      stall_if_en  = (p >= 2);
      stall_mem_en = (p == 3);
      @(negedge clk);
      check_value("data_write_o", 32'd0, 32'(data_write_o));
      check_value("data_read_o", 32'd0, 32'(data_read_o));
      check_value("inst_read_o", 32'd1, 32'(inst_read_o));
      while (inst_addr_o != LAST_PC) @(negedge clk);
      stall_if_en  = 0;
      stall_mem_en = 0;
      repeat (12) @(negedge clk);
      if (exp_idx < exp_addr.size()) begin
        $display("Program %0d ended with %0d expected stores never written", p,
                 exp_addr.size() - exp_idx);
      end
      missing_count += exp_addr.size() - exp_idx;
    end
    $display("Errors: %0d, missing stores: %0d", error_count, missing_count);
    if (error_count == 0 && missing_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
